//--- design/rng_defines.svh
// RNG subsystem parameters
`ifndef RNG_DEFINES_SVH
`define RNG_DEFINES_SVH

// Bus widths
`define RNG_ADDR_W 4
`define RNG_DATA_W 8

// Register offsets
`define RNG_OFF_RANDOM 4'h0
`define RNG_OFF_CTRL   4'h4
`define RNG_OFF_SEED   4'h8
`define RNG_OFF_ID     4'hC

// LFSR value after reset
`define RNG_SEED_RESET 8'h42

// Feedback mask, x^8+x^6+x^5+x^4+1
`define RNG_LFSR_TAPS 8'hB8

// Constant returned by the ID register
`define RNG_ID_VALUE 8'hA5

`endif

//--- design/rng_pkg.sv
// RNG subsystem types
`include "rng_defines.svh"

package rng_pkg;

    // Register map
    typedef enum logic [`RNG_ADDR_W-1:0] {
        REG_RANDOM = `RNG_OFF_RANDOM,
        REG_CTRL   = `RNG_OFF_CTRL,
        REG_SEED   = `RNG_OFF_SEED,
        REG_ID     = `RNG_OFF_ID
    } reg_addr_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    // Write channel FSM
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ACCEPT,
        WR_RESP
    } wr_state_e;

    // Read channel FSM
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ACCEPT,
        RD_RESP
    } rd_state_e;

    // Matches CTRL bit layout: bit 1 test_mode, bit 0 enable
    typedef struct packed {
        logic test_mode;
        logic enable;
    } rng_ctrl_t;

    typedef struct packed {
        logic                   load;
        logic [`RNG_DATA_W-1:0] value;
    } rng_seed_t;

endpackage

//--- design/entropy_sampler.sv
// Entropy source and synchronizer
module entropy_sampler (
    input  logic              clk_sys,
    input  logic              meta_clk,
    input  logic              rst_n,
    input  rng_pkg::rng_ctrl_t ctrl,
    output logic              entropy_bit
);

    logic toggle_q;
    logic toggle_en;
    logic [2:0] sync_q;

    // Oscillator runs only in normal mode
    assign toggle_en = ctrl.enable && !ctrl.test_mode;

    // Free-running toggle in the oscillator domain
    always_ff @(posedge meta_clk or negedge rst_n) begin
        if (!rst_n) begin
            toggle_q <= 1'b0;
        end else if (toggle_en) begin
            toggle_q <= ~toggle_q;
        end
    end

    // Three-stage synchronizer into clk_sys
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 3'b000;
        end else begin
            sync_q <= {sync_q[1:0], toggle_q};
        end
    end

    assign entropy_bit = sync_q[2];

endmodule

//--- design/rng_conditioner.sv
// LFSR entropy conditioner
`include "rng_defines.svh"

module rng_conditioner (
    input  logic                   clk_sys,
    input  logic                   rst_n,
    input  rng_pkg::rng_ctrl_t     ctrl,
    input  rng_pkg::rng_seed_t     seed,
    input  logic                   entropy_bit,
    input  logic                   pop,
    output logic [`RNG_DATA_W-1:0] sample
);

    logic [`RNG_DATA_W-1:0] lfsr_q;
    logic                   feedback;
    logic [`RNG_DATA_W-1:0] lfsr_det;
    logic [`RNG_DATA_W-1:0] lfsr_mixed;

    // Fibonacci feedback from the masked state bits
    assign feedback = ^(lfsr_q & `RNG_LFSR_TAPS);

    // Next state without and with entropy
    assign lfsr_det   = {lfsr_q[`RNG_DATA_W-2:0], feedback};
    assign lfsr_mixed = {lfsr_q[`RNG_DATA_W-2:0], feedback ^ entropy_bit};

    // Load wins, then test-mode pop, then free run, else hold.
    // A zero seed in test mode locks up at zero
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q <= `RNG_SEED_RESET;
        end else if (seed.load) begin
            lfsr_q <= seed.value;
        end else if (ctrl.test_mode) begin
            if (pop) begin
                lfsr_q <= lfsr_det;
            end
        end else if (ctrl.enable) begin
            lfsr_q <= lfsr_mixed;
        end
    end

    // Pop returns the state before the step
    assign sample = lfsr_q;

endmodule

//--- design/axil_rng_regs.sv
// AXI4-Lite register block
`include "rng_defines.svh"

module axil_rng_regs (
    input  logic                   clk_sys,
    input  logic                   rst_n,

    // Write address channel
    input  logic [`RNG_ADDR_W-1:0] s_axi_awaddr,
    input  logic                   s_axi_awvalid,
    output logic                   s_axi_awready,

    // Write data and response channels
    input  logic [`RNG_DATA_W-1:0] s_axi_wdata,
    input  logic [0:0]             s_axi_wstrb,
    input  logic                   s_axi_wvalid,
    output logic                   s_axi_wready,
    output logic [1:0]             s_axi_bresp,
    output logic                   s_axi_bvalid,
    input  logic                   s_axi_bready,

    // Read address channel
    input  logic [`RNG_ADDR_W-1:0] s_axi_araddr,
    input  logic                   s_axi_arvalid,
    output logic                   s_axi_arready,

    // Read data channel
    output logic [`RNG_DATA_W-1:0] s_axi_rdata,
    output logic [1:0]             s_axi_rresp,
    output logic                   s_axi_rvalid,
    input  logic                   s_axi_rready,

    output rng_pkg::rng_ctrl_t     ctrl,
    output rng_pkg::rng_seed_t     seed,
    output logic                   pop,
    input  logic [`RNG_DATA_W-1:0] sample
);

    rng_pkg::wr_state_e     wr_state;
    rng_pkg::rd_state_e     rd_state;
    rng_pkg::rng_ctrl_t     ctrl_q;
    rng_pkg::axi_resp_e     bresp_q;
    rng_pkg::axi_resp_e     rresp_q;
    logic [`RNG_DATA_W-1:0] rdata_q;

    logic                   wr_accept;
    logic                   wr_is_ctrl;
    logic                   wr_is_seed;
    rng_pkg::axi_resp_e     wr_resp;

    logic                   rd_accept;
    logic                   rd_is_random;
    rng_pkg::axi_resp_e     rd_resp;
    logic [`RNG_DATA_W-1:0] rd_data;

    assign wr_accept = (wr_state == rng_pkg::WR_ACCEPT);
    assign rd_accept = (rd_state == rng_pkg::RD_ACCEPT);

    // Write address decode
    always_comb begin
        wr_is_ctrl = 1'b0;
        wr_is_seed = 1'b0;
        wr_resp    = rng_pkg::RESP_SLVERR;
        case (rng_pkg::reg_addr_e'(s_axi_awaddr))
            rng_pkg::REG_CTRL: begin
                wr_is_ctrl = 1'b1;
                wr_resp    = rng_pkg::RESP_OKAY;
            end
            rng_pkg::REG_SEED: begin
                wr_is_seed = 1'b1;
                wr_resp    = rng_pkg::RESP_OKAY;
            end
            default: ;
        endcase
    end

    // Write FSM, also owns CTRL
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= rng_pkg::WR_IDLE;
            ctrl_q   <= '0;
        end else begin
            case (wr_state)
                rng_pkg::WR_IDLE: begin
                    if (s_axi_awvalid && s_axi_wvalid) begin
                        wr_state <= rng_pkg::WR_ACCEPT;
                    end
                end
                rng_pkg::WR_ACCEPT: begin
                    wr_state <= rng_pkg::WR_RESP;
                    if (wr_is_ctrl && s_axi_wstrb[0]) begin
                        ctrl_q <= rng_pkg::rng_ctrl_t'(s_axi_wdata[1:0]);
                    end
                end
                rng_pkg::WR_RESP: begin
                    if (s_axi_bready) begin
                        wr_state <= rng_pkg::WR_IDLE;
                    end
                end
                default: wr_state <= rng_pkg::WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (wr_accept) begin
            bresp_q <= wr_resp;
        end
    end

    // Read address decode
    always_comb begin
        rd_is_random = 1'b0;
        rd_data      = '0;
        rd_resp      = rng_pkg::RESP_OKAY;
        case (rng_pkg::reg_addr_e'(s_axi_araddr))
            rng_pkg::REG_RANDOM: begin
                rd_is_random = 1'b1;
                rd_data      = sample;
            end
            rng_pkg::REG_CTRL: rd_data = {{(`RNG_DATA_W-2){1'b0}}, ctrl_q};
            rng_pkg::REG_ID:   rd_data = `RNG_ID_VALUE;
            default:           rd_resp = rng_pkg::RESP_SLVERR;
        endcase
    end

    // Read FSM
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= rng_pkg::RD_IDLE;
        end else begin
            case (rd_state)
                rng_pkg::RD_IDLE: begin
                    if (s_axi_arvalid) begin
                        rd_state <= rng_pkg::RD_ACCEPT;
                    end
                end
                rng_pkg::RD_ACCEPT: rd_state <= rng_pkg::RD_RESP;
                rng_pkg::RD_RESP: begin
                    if (s_axi_rready) begin
                        rd_state <= rng_pkg::RD_IDLE;
                    end
                end
                default: rd_state <= rng_pkg::RD_IDLE;
            endcase
        end
    end

    // Sample is captured on the same edge the conditioner steps
    always_ff @(posedge clk_sys) begin
        if (rd_accept) begin
            rdata_q <= rd_data;
            rresp_q <= rd_resp;
        end
    end

    assign s_axi_awready = wr_accept;
    assign s_axi_wready  = wr_accept;
    assign s_axi_bvalid  = (wr_state == rng_pkg::WR_RESP);
    assign s_axi_bresp   = bresp_q;

    assign s_axi_arready = rd_accept;
    assign s_axi_rvalid  = (rd_state == rng_pkg::RD_RESP);
    assign s_axi_rdata   = rdata_q;
    assign s_axi_rresp   = rresp_q;

    assign ctrl       = ctrl_q;
    assign seed.load  = wr_accept && wr_is_seed && s_axi_wstrb[0];
    assign seed.value = s_axi_wdata;
    assign pop        = rd_accept && rd_is_random;

endmodule

//--- design/rng_axil_top.sv
// Memory-mapped RNG top level
`include "rng_defines.svh"

module rng_axil_top (
    input  logic                   clk_sys,
    input  logic                   rst_n,
    input  logic                   meta_clk,

    input  logic [`RNG_ADDR_W-1:0] s_axi_awaddr,
    input  logic                   s_axi_awvalid,
    output logic                   s_axi_awready,

    input  logic [`RNG_DATA_W-1:0] s_axi_wdata,
    input  logic [0:0]             s_axi_wstrb,
    input  logic                   s_axi_wvalid,
    output logic                   s_axi_wready,

    output logic [1:0]             s_axi_bresp,
    output logic                   s_axi_bvalid,
    input  logic                   s_axi_bready,

    input  logic [`RNG_ADDR_W-1:0] s_axi_araddr,
    input  logic                   s_axi_arvalid,
    output logic                   s_axi_arready,

    output logic [`RNG_DATA_W-1:0] s_axi_rdata,
    output logic [1:0]             s_axi_rresp,
    output logic                   s_axi_rvalid,
    input  logic                   s_axi_rready
);

    rng_pkg::rng_ctrl_t     ctrl;
    rng_pkg::rng_seed_t     seed;
    logic                   pop;
    logic                   entropy_bit;
    logic [`RNG_DATA_W-1:0] sample;

    entropy_sampler entropy_sampler_inst (
        .clk_sys     (clk_sys),
        .meta_clk    (meta_clk),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .entropy_bit (entropy_bit)
    );

    rng_conditioner rng_conditioner_inst (
        .clk_sys     (clk_sys),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .seed        (seed),
        .entropy_bit (entropy_bit),
        .pop         (pop),
        .sample      (sample)
    );

    axil_rng_regs axil_rng_regs_inst (
        .clk_sys       (clk_sys),
        .rst_n         (rst_n),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .ctrl          (ctrl),
        .seed          (seed),
        .pop           (pop),
        .sample        (sample)
    );

endmodule

//--- testbench/rng_checker.sv
// AXI4-Lite response checker
`include "rng_defines.svh"

module rng_checker (
    input  logic                   clk_sys,
    input  logic                   rst_n,
    input  logic                   s_axi_awvalid,
    input  logic                   s_axi_awready,
    input  logic                   s_axi_wvalid,
    input  logic                   s_axi_wready,
    input  logic [1:0]             s_axi_bresp,
    input  logic                   s_axi_bvalid,
    input  logic                   s_axi_bready,
    input  logic                   s_axi_arvalid,
    input  logic                   s_axi_arready,
    input  logic [`RNG_DATA_W-1:0] s_axi_rdata,
    input  logic [1:0]             s_axi_rresp,
    input  logic                   s_axi_rvalid,
    input  logic                   s_axi_rready,
    output int                     error_count,
    output int                     response_count
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FIELDS       = 6;
    localparam int MAX_OPS      = 64;
    localparam int RESP_LATENCY = 2;

    logic [7:0] ops_mem [0:FIELDS*MAX_OPS-1];
    int         cycle;
    int         wr_start;
    int         rd_start;
    int         wr_next;
    int         rd_next;
    logic       wr_pending;
    logic       rd_pending;

    function automatic string test_name(input logic [7:0] id);
        case (id)
            8'h01:   return "reset_defaults";
            8'h02:   return "register_access";
            8'h03:   return "seeded_sequence";
            8'h04:   return "test_mode_hold";
            8'h05:   return "normal_mode";
            default: return "unknown";
        endcase
    endfunction

    // Next line of the wanted kind or -1 past the end marker
    function automatic int find_op(input int from, input logic want_write);
        int         i;
        logic [7:0] kind;
        for (i = from; i < MAX_OPS; i++) begin
            kind = ops_mem[i*FIELDS];
            if (!(kind === 8'h01 || kind === 8'h02 || kind === 8'h03)) begin
                return -1;
            end
            if (want_write == (kind === 8'h01)) begin
                return i;
            end
        end
        return -1;
    endfunction

    initial begin
        $readmemh("testbench/rng_input.txt", ops_mem);
        wr_next        = find_op(0, 1'b1);
        rd_next        = find_op(0, 1'b0);
        error_count    = 0;
        response_count = 0;
        cycle          = 0;
        wr_pending     = 1'b0;
        rd_pending     = 1'b0;
    end

    // Ready pulses once, in the cycle after the request is seen
    task automatic compare_ready_pulses();
        logic wr_window;
        logic rd_window;
        wr_window = wr_pending && (cycle == wr_start + 1);
        rd_window = rd_pending && (cycle == rd_start + 1);
        if (s_axi_awready !== wr_window || s_axi_wready !== wr_window) begin
            $display("ERROR: write ready pulse missing or misplaced in cycle %0d", cycle);
            error_count++;
        end
        if (s_axi_arready !== rd_window) begin
            $display("ERROR: read ready pulse missing or misplaced in cycle %0d", cycle);
            error_count++;
        end
    endtask

    task automatic check_write_response();
        logic [7:0] exp_resp;
        if (cycle != wr_start + RESP_LATENCY) begin
            $display("ERROR: bvalid came %0d cycles after the write request instead of %0d",
                     cycle - wr_start, RESP_LATENCY);
            error_count++;
        end
        if (wr_next < 0) begin
            $display("ERROR: write response arrived with no write left in the stimulus file");
            error_count++;
            return;
        end
        exp_resp = ops_mem[wr_next*FIELDS+5];
        if (s_axi_bresp !== exp_resp[1:0]) begin
            $display("FAIL %s op %0d bresp expected %0d actual %0d",
                     test_name(ops_mem[wr_next*FIELDS+1]), wr_next, exp_resp[1:0], s_axi_bresp);
            error_count++;
        end
        response_count++;
        wr_next = find_op(wr_next + 1, 1'b1);
    endtask

    task automatic check_read_response();
        logic [7:0] exp_data;
        logic [7:0] exp_resp;
        if (cycle != rd_start + RESP_LATENCY) begin
            $display("ERROR: rvalid came %0d cycles after the read request instead of %0d",
                     cycle - rd_start, RESP_LATENCY);
            error_count++;
        end
        if (rd_next < 0) begin
            $display("ERROR: read response arrived with no read left in the stimulus file");
            error_count++;
            return;
        end
        exp_data = ops_mem[rd_next*FIELDS+4];
        exp_resp = ops_mem[rd_next*FIELDS+5];
        // Kind 3 data is entropy and stays unchecked
        if (ops_mem[rd_next*FIELDS] === 8'h02 && s_axi_rdata !== exp_data) begin
            $display("FAIL %s op %0d rdata expected 0x%02h actual 0x%02h",
                     test_name(ops_mem[rd_next*FIELDS+1]), rd_next, exp_data, s_axi_rdata);
            error_count++;
        end
        if (s_axi_rresp !== exp_resp[1:0]) begin
            $display("FAIL %s op %0d rresp expected %0d actual %0d",
                     test_name(ops_mem[rd_next*FIELDS+1]), rd_next, exp_resp[1:0], s_axi_rresp);
            error_count++;
        end
        response_count++;
        rd_next = find_op(rd_next + 1, 1'b0);
    endtask

    always @(posedge clk_sys) begin
        cycle = cycle + 1;
        if (!rst_n) begin
            wr_pending = 1'b0;
            rd_pending = 1'b0;
        end else begin
            compare_ready_pulses();

            if (s_axi_bvalid && s_axi_bready) begin
                if (!wr_pending) begin
                    $display("ERROR: write response appeared without a write request");
                    error_count++;
                end else begin
                    check_write_response();
                    wr_pending = 1'b0;
                end
            end else if (!wr_pending && s_axi_awvalid && s_axi_wvalid) begin
                wr_pending = 1'b1;
                wr_start   = cycle;
            end

            if (s_axi_rvalid && s_axi_rready) begin
                if (!rd_pending) begin
                    $display("ERROR: read response appeared without a read request");
                    error_count++;
                end else begin
                    check_read_response();
                    rd_pending = 1'b0;
                end
            end else if (!rd_pending && s_axi_arvalid) begin
                rd_pending = 1'b1;
                rd_start   = cycle;
            end
        end
    end

endmodule

//--- testbench/tb_rng_axil.sv
// AXI4-Lite RNG testbench
`include "rng_defines.svh"

module tb_rng_axil;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int  FIELDS      = 6;
    localparam int  MAX_OPS     = 64;
    localparam time CLK_HALF    = 50ns;
    localparam time META_HALF   = 37ns;
    localparam time DRIVE_DELAY = 10ns;

    logic                   clk_sys;
    logic                   meta_clk;
    logic                   rst_n;
    logic [`RNG_ADDR_W-1:0] s_axi_awaddr;
    logic                   s_axi_awvalid;
    logic                   s_axi_awready;
    logic [`RNG_DATA_W-1:0] s_axi_wdata;
    logic [0:0]             s_axi_wstrb;
    logic                   s_axi_wvalid;
    logic                   s_axi_wready;
    logic [1:0]             s_axi_bresp;
    logic                   s_axi_bvalid;
    logic                   s_axi_bready;
    logic [`RNG_ADDR_W-1:0] s_axi_araddr;
    logic                   s_axi_arvalid;
    logic                   s_axi_arready;
    logic [`RNG_DATA_W-1:0] s_axi_rdata;
    logic [1:0]             s_axi_rresp;
    logic                   s_axi_rvalid;
    logic                   s_axi_rready;

    // Six hex fields per operation
    logic [7:0] ops_mem [0:FIELDS*MAX_OPS-1];
    int         n_ops;
    int         error_count;
    int         response_count;

    rng_axil_top rng_axil_top_inst (.*);

    rng_checker rng_checker_inst (
        .clk_sys        (clk_sys),
        .rst_n          (rst_n),
        .s_axi_awvalid  (s_axi_awvalid),
        .s_axi_awready  (s_axi_awready),
        .s_axi_wvalid   (s_axi_wvalid),
        .s_axi_wready   (s_axi_wready),
        .s_axi_bresp    (s_axi_bresp),
        .s_axi_bvalid   (s_axi_bvalid),
        .s_axi_bready   (s_axi_bready),
        .s_axi_arvalid  (s_axi_arvalid),
        .s_axi_arready  (s_axi_arready),
        .s_axi_rdata    (s_axi_rdata),
        .s_axi_rresp    (s_axi_rresp),
        .s_axi_rvalid   (s_axi_rvalid),
        .s_axi_rready   (s_axi_rready),
        .error_count    (error_count),
        .response_count (response_count)
    );

    initial begin
        clk_sys = 1'b0;
        forever #CLK_HALF clk_sys = ~clk_sys;
    end

    // Oscillator with no relation to clk_sys
    initial begin
        meta_clk = 1'b0;
        forever #META_HALF meta_clk = ~meta_clk;
    end

    function automatic int count_ops();
        int  n;
        logic [7:0] kind;
        n = 0;
        kind = ops_mem[0];
        while (n < MAX_OPS && (kind === 8'h01 || kind === 8'h02 || kind === 8'h03)) begin
            n++;
            if (n < MAX_OPS) begin
                kind = ops_mem[n*FIELDS];
            end
        end
        return n;
    endfunction

    task automatic write_register(input logic [`RNG_ADDR_W-1:0] addr,
                                  input logic [`RNG_DATA_W-1:0] data);
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        @(posedge clk_sys);
        while (!(s_axi_awready && s_axi_wready)) @(posedge clk_sys);
        #DRIVE_DELAY;
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        @(posedge clk_sys);
        while (!s_axi_bvalid) @(posedge clk_sys);
        #DRIVE_DELAY;
    endtask

    task automatic read_register(input logic [`RNG_ADDR_W-1:0] addr);
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        @(posedge clk_sys);
        while (!s_axi_arready) @(posedge clk_sys);
        #DRIVE_DELAY;
        s_axi_arvalid = 1'b0;
        @(posedge clk_sys);
        while (!s_axi_rvalid) @(posedge clk_sys);
        #DRIVE_DELAY;
    endtask

    // Cycle budget scales with the number of operations
    initial begin : watchdog
        int limit;
        #1;
        limit = n_ops * 20 + 100;
        repeat (limit) @(posedge clk_sys);
        $display("Timeout: operations did not complete within %0d clock cycles", limit);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : driver
        int         idx;
        int         missing;
        logic [7:0] kind;
        rst_n         = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = 1'b1;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b1;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b1;
        $readmemh("testbench/rng_input.txt", ops_mem);
        n_ops = count_ops();
        if (n_ops == 0) begin
            $display("No operations could be read from the stimulus file");
        end

        repeat (2) @(posedge clk_sys);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        for (idx = 0; idx < n_ops; idx++) begin
            kind = ops_mem[idx*FIELDS];
            if (kind == 8'h01) begin
                write_register(ops_mem[idx*FIELDS+2][`RNG_ADDR_W-1:0], ops_mem[idx*FIELDS+3]);
            end else begin
                read_register(ops_mem[idx*FIELDS+2][`RNG_ADDR_W-1:0]);
            end
        end

        repeat (3) @(posedge clk_sys);
        missing = n_ops - response_count;
        $display("Errors: %0d check failures, %0d missing responses", error_count, missing);
        if (error_count == 0 && missing == 0 && n_ops > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/rng_input.txt
// One operation per line, all fields hex: kind test addr wdata rdata resp
// kind 1 write, 2 read, 3 read with rdata unchecked; resp 0 OKAY, 2 SLVERR
// Reset defaults
2 1 c 00 a5 0
2 1 4 00 00 0
// Register access and error responses
1 2 4 03 00 0
2 2 4 00 03 0
1 2 c 55 00 2
1 2 0 77 00 2
2 2 8 00 00 2
2 2 2 00 00 2
2 2 c 00 a5 0
2 2 4 00 03 0
2 2 0 00 42 0
// Seeded sequence in test mode, taps 0xB8
1 3 8 c3 00 0
2 3 0 00 c3 0
2 3 0 00 87 0
2 3 0 00 0f 0
2 3 0 00 1f 0
// Test mode with enable cleared
1 4 4 02 00 0
2 4 4 00 02 0
2 4 0 00 3e 0
2 4 4 00 02 0
2 4 0 00 7d 0
2 4 c 00 a5 0
2 4 0 00 fb 0
2 4 0 00 f6 0
// Normal mode with entropy mixed in
1 5 4 01 00 0
2 5 4 00 01 0
3 5 0 00 00 0
3 5 0 00 00 0
3 5 0 00 00 0
3 5 0 00 00 0
1 5 4 00 00 0
2 5 4 00 00 0
// End marker
0 0 0 00 00 0

//--- vlog.f
+incdir+design
design/rng_pkg.sv
design/entropy_sampler.sv
design/rng_conditioner.sv
design/axil_rng_regs.sv
design/rng_axil_top.sv
testbench/rng_checker.sv
testbench/tb_rng_axil.sv

//--- Bender.yml
package:
  name: rng_axil

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/rng_pkg.sv
      - design/entropy_sampler.sv
      - design/rng_conditioner.sv
      - design/axil_rng_regs.sv
      - design/rng_axil_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/rng_checker.sv
      - testbench/tb_rng_axil.sv
